/* mem_subsys_macros.svh */
`ifndef MEM_SUBSYS_MACROS_SVH
`define MEM_SUBSYS_MACROS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

// byte address width seen by both ports and the AXI side.
`define MS_ADDR_WIDTH 32

// data width of one access.
`define MS_DATA_WIDTH 32

// one strobe bit per data byte.
`define MS_STRB_WIDTH 4

//////////////////////////////
// memory
//////////////////////////////

// depth of the SRAM in words, a power of two.
`define MS_SRAM_WORDS 256

`endif

/* mem_subsys_pkg.sv */
`include "mem_subsys_macros.svh"

package mem_subsys_pkg;

    typedef logic [`MS_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MS_DATA_WIDTH-1:0] data_t;
    typedef logic [`MS_STRB_WIDTH-1:0] strb_t;

    typedef logic [1:0] resp_t;  // AXI bresp/rresp encoding.

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // grant state of the port arbiter.
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_IFU,
        ARB_LSU
    } arb_state_t;

    // bridge sequencing, one transaction at a time.
    typedef enum logic [2:0] {
        MST_IDLE,
        MST_AR,
        MST_R,
        MST_AW_W,
        MST_B,
        MST_DONE
    } mst_state_t;

endpackage

/* cpu_bus_if.sv */
`timescale 1ns/1ps
`include "mem_subsys_macros.svh"

interface cpu_bus_if;

    // read request and its completion.
    logic                  r_valid;
    mem_subsys_pkg::addr_t r_addr;
    logic                  r_ready;  // one-cycle pulse.
    mem_subsys_pkg::data_t r_data;   // valid while r_ready is high.

    // write request and its completion.
    logic                  w_valid;
    mem_subsys_pkg::addr_t w_addr;
    mem_subsys_pkg::data_t w_data;
    mem_subsys_pkg::strb_t w_strb;
    logic                  w_ready;

    modport arb (
        output r_valid,
        output r_addr,
        input  r_ready,
        input  r_data,
        output w_valid,
        output w_addr,
        output w_data,
        output w_strb,
        input  w_ready
    );

    modport mst (
        input  r_valid,
        input  r_addr,
        output r_ready,
        output r_data,
        input  w_valid,
        input  w_addr,
        input  w_data,
        input  w_strb,
        output w_ready
    );

endinterface

/* axi_lite_if.sv */
`timescale 1ns/1ps
`include "mem_subsys_macros.svh"

interface axi_lite_if;

    //////////////////////////////
    // write channels
    //////////////////////////////
    logic                  awvalid;
    logic                  awready;
    mem_subsys_pkg::addr_t awaddr;
    logic [2:0]            awprot;

    logic                  wvalid;
    logic                  wready;
    mem_subsys_pkg::data_t wdata;
    mem_subsys_pkg::strb_t wstrb;

    logic                  bvalid;
    logic                  bready;
    mem_subsys_pkg::resp_t bresp;

    //////////////////////////////
    // read channels
    //////////////////////////////
    logic                  arvalid;
    logic                  arready;
    mem_subsys_pkg::addr_t araddr;
    logic [2:0]            arprot;

    logic                  rvalid;
    logic                  rready;
    mem_subsys_pkg::data_t rdata;
    mem_subsys_pkg::resp_t rresp;

    modport master (
        output awvalid, awaddr, awprot, input awready,
        output wvalid, wdata, wstrb, input wready,
        input  bvalid, bresp, output bready,
        output arvalid, araddr, arprot, input arready,
        input  rvalid, rdata, rresp, output rready
    );

    modport slave (
        input  awvalid, awaddr, awprot, output awready,
        input  wvalid, wdata, wstrb, output wready,
        output bvalid, bresp, input bready,
        input  arvalid, araddr, arprot, output arready,
        output rvalid, rdata, rresp, input rready
    );

endinterface

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                  aclk,
    input  logic                  areset_n,

    input  logic                  ifu_r_valid_i,
    input  mem_subsys_pkg::addr_t ifu_r_addr_i,
    output logic                  ifu_r_ready_o,
    output mem_subsys_pkg::data_t ifu_r_data_o,

    input  logic                  lsu_r_valid_i,
    input  mem_subsys_pkg::addr_t lsu_r_addr_i,
    output logic                  lsu_r_ready_o,
    output mem_subsys_pkg::data_t lsu_r_data_o,

    input  logic                  lsu_w_valid_i,
    input  mem_subsys_pkg::addr_t lsu_w_addr_i,
    input  mem_subsys_pkg::data_t lsu_w_data_i,
    input  mem_subsys_pkg::strb_t lsu_w_strb_i,
    output logic                  lsu_w_ready_o,

    cpu_bus_if.arb                cpu
);

    mem_subsys_pkg::arb_state_t state_q;

    logic grant_ifu;
    logic grant_lsu;
    logic lsu_req;

    assign grant_ifu = (state_q == mem_subsys_pkg::ARB_IFU);
    assign grant_lsu = (state_q == mem_subsys_pkg::ARB_LSU);
    assign lsu_req   = lsu_r_valid_i | lsu_w_valid_i;

    //////////////////////////////
    // request multiplexing
    //////////////////////////////

    // only the LSU ever writes, so the write set follows the LSU grant alone.
    assign cpu.r_valid = grant_ifu ? ifu_r_valid_i : (grant_lsu & lsu_r_valid_i);
    assign cpu.r_addr  = grant_ifu ? ifu_r_addr_i  : (grant_lsu ? lsu_r_addr_i : '0);

    assign cpu.w_valid = grant_lsu & lsu_w_valid_i;
    assign cpu.w_addr  = grant_lsu ? lsu_w_addr_i : '0;
    assign cpu.w_data  = grant_lsu ? lsu_w_data_i : '0;
    assign cpu.w_strb  = grant_lsu ? lsu_w_strb_i : '0;

    // completions go back only to the port holding the grant.
    assign ifu_r_ready_o = grant_ifu & cpu.r_ready;
    assign ifu_r_data_o  = grant_ifu ? cpu.r_data : '0;
    assign lsu_r_ready_o = grant_lsu & cpu.r_ready;
    assign lsu_r_data_o  = grant_lsu ? cpu.r_data : '0;
    assign lsu_w_ready_o = grant_lsu & cpu.w_ready;

    //////////////////////////////
    // grant state
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            state_q <= mem_subsys_pkg::ARB_IDLE;
        end else begin
            case (state_q)
                mem_subsys_pkg::ARB_IDLE: begin
                    if (lsu_req) begin
                        state_q <= mem_subsys_pkg::ARB_LSU;  // the LSU wins a tie.
                    end else if (ifu_r_valid_i) begin
                        state_q <= mem_subsys_pkg::ARB_IFU;
                    end
                end
                mem_subsys_pkg::ARB_IFU: begin
                    if (cpu.r_ready) begin
                        // a waiting LSU is handed the bus without passing through idle.
                        state_q <= lsu_req ? mem_subsys_pkg::ARB_LSU : mem_subsys_pkg::ARB_IDLE;
                    end
                end
                mem_subsys_pkg::ARB_LSU: begin
                    if (cpu.r_ready || cpu.w_ready) begin
                        state_q <= mem_subsys_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state_q <= mem_subsys_pkg::ARB_IDLE;
                end
            endcase
        end
    end

endmodule

/* axi_lite_master.sv */
`timescale 1ns/1ps

module axi_lite_master (
    input  logic       aclk,
    input  logic       areset_n,
    cpu_bus_if.mst     cpu,
    axi_lite_if.master axi
);

    mem_subsys_pkg::mst_state_t state_q;

    logic                  is_write_q;  // kind of the transaction in flight.
    logic                  aw_done_q;
    logic                  w_done_q;
    mem_subsys_pkg::data_t rdata_q;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;
    logic aw_have;
    logic w_have;

    assign aw_fire = axi.awvalid & axi.awready;
    assign w_fire  = axi.wvalid & axi.wready;
    assign b_fire  = axi.bvalid & axi.bready;
    assign ar_fire = axi.arvalid & axi.arready;
    assign r_fire  = axi.rvalid & axi.rready;

    // AW and W may complete in either order, or together.
    assign aw_have = aw_done_q | aw_fire;
    assign w_have  = w_done_q | w_fire;

    //////////////////////////////
    // AXI side
    //////////////////////////////

    // the arbiter holds the request fields until ready, so they drive AXI directly.
    assign axi.awvalid = (state_q == mem_subsys_pkg::MST_AW_W) & ~aw_done_q;
    assign axi.awaddr  = cpu.w_addr;
    assign axi.awprot  = 3'b000;  // unprivileged, secure, data.
    assign axi.wvalid  = (state_q == mem_subsys_pkg::MST_AW_W) & ~w_done_q;
    assign axi.wdata   = cpu.w_data;
    assign axi.wstrb   = cpu.w_strb;
    assign axi.bready  = (state_q == mem_subsys_pkg::MST_B);

    assign axi.arvalid = (state_q == mem_subsys_pkg::MST_AR);
    assign axi.araddr  = cpu.r_addr;
    assign axi.arprot  = 3'b000;
    assign axi.rready  = (state_q == mem_subsys_pkg::MST_R);

    //////////////////////////////
    // CPU side
    //////////////////////////////
    assign cpu.r_ready = (state_q == mem_subsys_pkg::MST_DONE) & ~is_write_q;
    assign cpu.w_ready = (state_q == mem_subsys_pkg::MST_DONE) & is_write_q;
    assign cpu.r_data  = rdata_q;

    always_ff @(posedge aclk) begin
        if (r_fire) begin
            rdata_q <= axi.rdata;  // the response code is not passed on.
        end
    end

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            state_q    <= mem_subsys_pkg::MST_IDLE;
            is_write_q <= 1'b0;
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
        end else begin
            case (state_q)
                mem_subsys_pkg::MST_IDLE: begin
                    // a write is served first when the LSU shows both.
                    if (cpu.w_valid) begin
                        state_q    <= mem_subsys_pkg::MST_AW_W;
                        is_write_q <= 1'b1;
                    end else if (cpu.r_valid) begin
                        state_q    <= mem_subsys_pkg::MST_AR;
                        is_write_q <= 1'b0;
                    end
                end
                mem_subsys_pkg::MST_AR: begin
                    if (ar_fire) state_q <= mem_subsys_pkg::MST_R;
                end
                mem_subsys_pkg::MST_R: begin
                    if (r_fire) state_q <= mem_subsys_pkg::MST_DONE;
                end
                mem_subsys_pkg::MST_AW_W: begin
                    if (aw_have && w_have) begin
                        state_q   <= mem_subsys_pkg::MST_B;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end else begin
                        aw_done_q <= aw_have;
                        w_done_q  <= w_have;
                    end
                end
                mem_subsys_pkg::MST_B: begin
                    if (b_fire) state_q <= mem_subsys_pkg::MST_DONE;
                end
                default: begin
                    // done holds for one cycle while the arbiter moves on.
                    state_q <= mem_subsys_pkg::MST_IDLE;
                end
            endcase
        end
    end

endmodule

/* axi_lite_sram.sv */
`timescale 1ns/1ps
`include "mem_subsys_macros.svh"

module axi_lite_sram (
    input  logic      aclk,
    input  logic      areset_n,
    axi_lite_if.slave axi
);

    localparam int IDX_W = $clog2(`MS_SRAM_WORDS);
    localparam int LSB_W = $clog2(`MS_STRB_WIDTH);

    mem_subsys_pkg::data_t mem_q [`MS_SRAM_WORDS];

    logic                  aw_got_q;
    logic                  w_got_q;
    mem_subsys_pkg::addr_t awaddr_q;
    mem_subsys_pkg::data_t wdata_q;
    mem_subsys_pkg::strb_t wstrb_q;
    logic                  bvalid_q;
    mem_subsys_pkg::resp_t bresp_q;
    logic                  rvalid_q;
    mem_subsys_pkg::data_t rdata_q;
    mem_subsys_pkg::resp_t rresp_q;

    logic                  aw_fire;
    logic                  w_fire;
    logic                  ar_fire;
    logic                  wr_go;
    mem_subsys_pkg::addr_t wr_addr;
    mem_subsys_pkg::data_t wr_data;
    mem_subsys_pkg::strb_t wr_strb;

    // the address is in range when every bit above the word index is zero.
    function automatic logic in_range(mem_subsys_pkg::addr_t a);
        return a[`MS_ADDR_WIDTH-1:IDX_W+LSB_W] == '0;
    endfunction

    function automatic logic [IDX_W-1:0] word_idx(mem_subsys_pkg::addr_t a);
        return a[IDX_W+LSB_W-1:LSB_W];
    endfunction

    assign axi.awready = ~aw_got_q & ~bvalid_q;
    assign axi.wready  = ~w_got_q & ~bvalid_q;
    assign axi.bvalid  = bvalid_q;
    assign axi.bresp   = bresp_q;
    assign axi.arready = ~rvalid_q;  // one read response held at a time.
    assign axi.rvalid  = rvalid_q;
    assign axi.rdata   = rdata_q;
    assign axi.rresp   = rresp_q;

    assign aw_fire = axi.awvalid & axi.awready;
    assign w_fire  = axi.wvalid & axi.wready;
    assign ar_fire = axi.arvalid & axi.arready;

    // the write goes ahead in the cycle the second of AW and W arrives.
    assign wr_go   = (aw_got_q | aw_fire) & (w_got_q | w_fire);
    assign wr_addr = aw_got_q ? awaddr_q : axi.awaddr;
    assign wr_data = w_got_q ? wdata_q : axi.wdata;
    assign wr_strb = w_got_q ? wstrb_q : axi.wstrb;

    //////////////////////////////
    // storage
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (aw_fire) awaddr_q <= axi.awaddr;
        if (w_fire) begin
            wdata_q <= axi.wdata;
            wstrb_q <= axi.wstrb;
        end
        if (wr_go && in_range(wr_addr)) begin
            for (int b = 0; b < `MS_STRB_WIDTH; b++) begin
                if (wr_strb[b]) mem_q[word_idx(wr_addr)][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
        if (ar_fire) begin
            rdata_q <= in_range(axi.araddr) ? mem_q[word_idx(axi.araddr)] : '0;
        end
    end

    //////////////////////////////
    // channel control
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            aw_got_q <= 1'b0;
            w_got_q  <= 1'b0;
            bvalid_q <= 1'b0;
            bresp_q  <= mem_subsys_pkg::RESP_OKAY;
            rvalid_q <= 1'b0;
            rresp_q  <= mem_subsys_pkg::RESP_OKAY;
        end else begin
            if (wr_go) begin
                aw_got_q <= 1'b0;
                w_got_q  <= 1'b0;
                bvalid_q <= 1'b1;
                bresp_q  <= in_range(wr_addr) ? mem_subsys_pkg::RESP_OKAY
                                              : mem_subsys_pkg::RESP_DECERR;
            end else begin
                aw_got_q <= aw_got_q | aw_fire;
                w_got_q  <= w_got_q | w_fire;
                if (axi.bready) bvalid_q <= 1'b0;  // B stays up under back-pressure.
            end
            if (ar_fire) begin
                rvalid_q <= 1'b1;
                rresp_q  <= in_range(axi.araddr) ? mem_subsys_pkg::RESP_OKAY
                                                 : mem_subsys_pkg::RESP_DECERR;
            end else if (axi.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                  aclk,
    input  logic                  areset_n,

    // instruction fetch, read only.
    input  logic                  ifu_r_valid_i,
    input  mem_subsys_pkg::addr_t ifu_r_addr_i,
    output logic                  ifu_r_ready_o,
    output mem_subsys_pkg::data_t ifu_r_data_o,

    // load/store, read side.
    input  logic                  lsu_r_valid_i,
    input  mem_subsys_pkg::addr_t lsu_r_addr_i,
    output logic                  lsu_r_ready_o,
    output mem_subsys_pkg::data_t lsu_r_data_o,

    // load/store, write side.
    input  logic                  lsu_w_valid_i,
    input  mem_subsys_pkg::addr_t lsu_w_addr_i,
    input  mem_subsys_pkg::data_t lsu_w_data_i,
    input  mem_subsys_pkg::strb_t lsu_w_strb_i,
    output logic                  lsu_w_ready_o
);

    cpu_bus_if  cpu_bus ();
    axi_lite_if axi_bus ();

    mem_arbiter u_arbiter (
        .aclk          (aclk),
        .areset_n      (areset_n),
        .ifu_r_valid_i (ifu_r_valid_i),
        .ifu_r_addr_i  (ifu_r_addr_i),
        .ifu_r_ready_o (ifu_r_ready_o),
        .ifu_r_data_o  (ifu_r_data_o),
        .lsu_r_valid_i (lsu_r_valid_i),
        .lsu_r_addr_i  (lsu_r_addr_i),
        .lsu_r_ready_o (lsu_r_ready_o),
        .lsu_r_data_o  (lsu_r_data_o),
        .lsu_w_valid_i (lsu_w_valid_i),
        .lsu_w_addr_i  (lsu_w_addr_i),
        .lsu_w_data_i  (lsu_w_data_i),
        .lsu_w_strb_i  (lsu_w_strb_i),
        .lsu_w_ready_o (lsu_w_ready_o),
        .cpu           (cpu_bus.arb)
    );

    axi_lite_master u_master (
        .aclk     (aclk),
        .areset_n (areset_n),
        .cpu      (cpu_bus.mst),
        .axi      (axi_bus.master)
    );

    axi_lite_sram u_sram (
        .aclk     (aclk),
        .areset_n (areset_n),
        .axi      (axi_bus.slave)
    );

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ps
`include "mem_subsys_macros.svh"

module tb_mem_subsys;

    localparam int CLK_PERIOD     = 100;
    localparam int N_ADDR         = 8;
    localparam int N_TXN          = 4*N_ADDR + 7;
    localparam int TIMEOUT_CYCLES = N_TXN*20 + 100;  // about 20 cycles per transaction.

    logic                  aclk;
    logic                  areset_n;
    logic                  ifu_r_valid_i;
    mem_subsys_pkg::addr_t ifu_r_addr_i;
    logic                  ifu_r_ready_o;
    mem_subsys_pkg::data_t ifu_r_data_o;
    logic                  lsu_r_valid_i;
    mem_subsys_pkg::addr_t lsu_r_addr_i;
    logic                  lsu_r_ready_o;
    mem_subsys_pkg::data_t lsu_r_data_o;
    logic                  lsu_w_valid_i;
    mem_subsys_pkg::addr_t lsu_w_addr_i;
    mem_subsys_pkg::data_t lsu_w_data_i;
    mem_subsys_pkg::strb_t lsu_w_strb_i;
    logic                  lsu_w_ready_o;

    int   err_count    = 0;
    int   err_at_start = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    logic started      = 1'b0;  // set with the first request.

    // expected SRAM contents, keyed by word-aligned byte address.
    mem_subsys_pkg::data_t model [mem_subsys_pkg::addr_t];
    mem_subsys_pkg::addr_t addrs [N_ADDR];

    mem_subsys_top DUT (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD/2) aclk = ~aclk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////
    // assertions
    //////////////////////////////
    assert property (@(posedge aclk) started || !(ifu_r_ready_o || lsu_r_ready_o || lsu_w_ready_o))
        else begin
            $display("a port ready went high before any request was made");
            err_count++;
        end

    assert property (@(posedge aclk) $onehot0({ifu_r_ready_o, lsu_r_ready_o, lsu_w_ready_o}))
        else begin
            $display("CHECK FAILED {ifu_r_ready_o,lsu_r_ready_o,lsu_w_ready_o} = 0x%h",
                     $sampled({ifu_r_ready_o, lsu_r_ready_o, lsu_w_ready_o}));
            err_count++;
        end

    assert property (@(posedge aclk) !(ifu_r_ready_o && $past(ifu_r_ready_o)))
        else begin
            $display("ifu_r_ready_o stayed high for more than one cycle");
            err_count++;
        end

    assert property (@(posedge aclk) !(lsu_r_ready_o && $past(lsu_r_ready_o)))
        else begin
            $display("lsu_r_ready_o stayed high for more than one cycle");
            err_count++;
        end

    assert property (@(posedge aclk) !(lsu_w_ready_o && $past(lsu_w_ready_o)))
        else begin
            $display("lsu_w_ready_o stayed high for more than one cycle");
            err_count++;
        end

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic mem_subsys_pkg::addr_t rand_word_addr();
        return $urandom() & ((`MS_SRAM_WORDS - 1) << $clog2(`MS_STRB_WIDTH));
    endfunction

    // strobed bytes take the new value, the rest keep the old one.
    function automatic mem_subsys_pkg::data_t merge_bytes(mem_subsys_pkg::data_t old_w,
            mem_subsys_pkg::data_t new_w, mem_subsys_pkg::strb_t strb);
        mem_subsys_pkg::data_t res;
        res = old_w;
        for (int b = 0; b < `MS_STRB_WIDTH; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_value(input string name, input mem_subsys_pkg::data_t got,
            input mem_subsys_pkg::data_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic lsu_write(input mem_subsys_pkg::addr_t a, input mem_subsys_pkg::data_t d,
            input mem_subsys_pkg::strb_t s, output time t_done);
        @(posedge aclk);
        started       <= 1'b1;
        lsu_w_valid_i <= 1'b1;
        lsu_w_addr_i  <= a;
        lsu_w_data_i  <= d;
        lsu_w_strb_i  <= s;
        @(negedge aclk);
        while (!lsu_w_ready_o) @(negedge aclk);
        t_done = $time;
        @(posedge aclk);
        lsu_w_valid_i <= 1'b0;
    endtask

    task automatic lsu_read(input mem_subsys_pkg::addr_t a, output mem_subsys_pkg::data_t d);
        @(posedge aclk);
        started       <= 1'b1;
        lsu_r_valid_i <= 1'b1;
        lsu_r_addr_i  <= a;
        @(negedge aclk);
        while (!lsu_r_ready_o) @(negedge aclk);
        d = lsu_r_data_o;  // data is only valid in the ready cycle.
        @(posedge aclk);
        lsu_r_valid_i <= 1'b0;
    endtask

    task automatic ifu_read(input mem_subsys_pkg::addr_t a, output mem_subsys_pkg::data_t d,
            output time t_done);
        @(posedge aclk);
        started       <= 1'b1;
        ifu_r_valid_i <= 1'b1;
        ifu_r_addr_i  <= a;
        @(negedge aclk);
        while (!ifu_r_ready_o) @(negedge aclk);
        d      = ifu_r_data_o;
        t_done = $time;
        @(posedge aclk);
        ifu_r_valid_i <= 1'b0;
    endtask

    task automatic start_test();
        err_at_start = err_count;
    endtask

    task automatic finish_test(input string name);
        if (err_count == err_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - err_at_start);
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////
    initial begin
        mem_subsys_pkg::data_t rd;
        mem_subsys_pkg::data_t wd;
        mem_subsys_pkg::data_t exp_ifu;
        mem_subsys_pkg::strb_t st;
        mem_subsys_pkg::addr_t wa;
        mem_subsys_pkg::addr_t oob;
        time                   t_lsu;
        time                   t_ifu;
        int unsigned           pick;

        void'($urandom(32'h759f769b));
        areset_n      <= 1'b0;
        ifu_r_valid_i <= 1'b0;
        ifu_r_addr_i  <= '0;
        lsu_r_valid_i <= 1'b0;
        lsu_r_addr_i  <= '0;
        lsu_w_valid_i <= 1'b0;
        lsu_w_addr_i  <= '0;
        lsu_w_data_i  <= '0;
        lsu_w_strb_i  <= '0;
        repeat (2) @(posedge aclk);
        areset_n <= 1'b1;

        start_test();
        repeat (4) @(posedge aclk);
        finish_test("readies low after reset");

        start_test();
        for (int i = 0; i < N_ADDR; i++) begin
            addrs[i] = rand_word_addr();
            wd       = $urandom();
            lsu_write(addrs[i], wd, '1, t_lsu);
            model[addrs[i]] = wd;
        end
        for (int i = 0; i < N_ADDR; i++) begin
            lsu_read(addrs[i], rd);
            check_value("lsu_r_data_o", rd, model[addrs[i]]);
        end
        finish_test("lsu write then read");

        start_test();
        for (int i = 0; i < N_ADDR; i++) begin
            ifu_read(addrs[i], rd, t_ifu);
            check_value("ifu_r_data_o", rd, model[addrs[i]]);
        end
        wd = $urandom();
        lsu_write(addrs[0], wd, 4'b0101, t_lsu);
        model[addrs[0]] = merge_bytes(model[addrs[0]], wd, 4'b0101);
        lsu_read(addrs[0], rd);
        check_value("lsu_r_data_o", rd, model[addrs[0]]);
        finish_test("ifu reads and partial strobe");

        // the LSU goes first, so the IFU read sees the model after the write.
        start_test();
        wa        = rand_word_addr();
        wd        = $urandom();
        model[wa] = wd;
        exp_ifu   = model[addrs[2]];
        fork
            lsu_write(wa, wd, '1, t_lsu);
            ifu_read(addrs[2], rd, t_ifu);
        join
        check_value("ifu_r_data_o", rd, exp_ifu);
        assert (t_lsu < t_ifu) else begin
            $display("the LSU ready pulse did not come before the IFU ready pulse");
            err_count++;
        end
        finish_test("lsu priority on a tie");

        start_test();
        oob = addrs[1] | 32'h8000_0000;  // aliases addrs[1] in the low bits.
        lsu_write(oob, ~model[addrs[1]], '1, t_lsu);
        lsu_read(addrs[1], rd);
        check_value("lsu_r_data_o", rd, model[addrs[1]]);
        lsu_read(oob, rd);
        check_value("lsu_r_data_o", rd, '0);
        finish_test("out of range access");

        start_test();
        for (int i = 0; i < N_ADDR; i++) begin
            pick = $urandom_range(0, 2);
            wa   = addrs[$urandom_range(0, N_ADDR-1)];
            case (pick)
                0: begin
                    wd = $urandom();
                    st = wd[`MS_STRB_WIDTH-1:0];
                    wd = $urandom();
                    lsu_write(wa, wd, st, t_lsu);
                    model[wa] = merge_bytes(model[wa], wd, st);
                end
                1: begin
                    lsu_read(wa, rd);
                    check_value("lsu_r_data_o", rd, model[wa]);
                end
                default: begin
                    ifu_read(wa, rd, t_ifu);
                    check_value("ifu_r_data_o", rd, model[wa]);
                end
            endcase
        end
        finish_test("random mixed traffic");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
mem_subsys_pkg.sv
cpu_bus_if.sv
axi_lite_if.sv
mem_arbiter.sv
axi_lite_master.sv
axi_lite_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the simulation prints the pass line.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f --top-module tb_mem_subsys -o sim_mem_subsys \
    && ./obj_dir/sim_mem_subsys | tee /dev/stderr | grep -qx "Test passed" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
